/* filelist.f */
+incdir+verification
hw/periph_pkg.sv
hw/periph_addr_decode.sv
hw/read_data_hold.sv
hw/gpio_ctrl.sv
hw/out_pin_mux.sv
hw/interval_timer.sv
hw/byte_reg_bank.sv
hw/periph_bus_top.sv
verification/tb_periph_bus.sv

/* hw/byte_reg_bank.sv */
/*
 * Byte register bank
 * Sixteen read/write byte registers; register 0 drives the pins
 */
module byte_reg_bank (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       i_write,
    input  logic [3:0] i_offset,
    input  logic [7:0] i_data,
    output logic [7:0] o_data,
    output logic [7:0] o_pins
);

    logic [7:0] regs_q [16];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int r = 0; r < 16; r++) begin
                regs_q[r] <= '0;
            end
        end else if (i_write) begin
            regs_q[i_offset] <= i_data;
        end
    end

    assign o_data = regs_q[i_offset];
    assign o_pins = regs_q[0];

endmodule

/* hw/gpio_ctrl.sv */
/*
 * GPIO controller
 * Output register, input pin readback and one function-select
 * register per output pin
 */
module gpio_ctrl #(
    parameter int num_pins = 8
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    i_sel,
    input  periph_pkg::periph_req_t i_req,
    input  logic [num_pins-1:0]     i_ui_in,
    output periph_pkg::periph_rsp_t o_rsp,
    output logic [num_pins-1:0]     o_pins,
    output periph_pkg::func_sel_t   o_func_sel [num_pins]
);
    import periph_pkg::*;

    localparam logic [5:0] off_out = 6'h00;
    localparam logic [5:0] off_in  = 6'h04;

    localparam func_sel_t sel_timer = '{simple: 1'b0, slot: 4'(slot_timer)};
    localparam func_sel_t sel_gpio  = '{simple: 1'b0, slot: 4'(slot_gpio)};

    logic                wr_en;
    logic                fsel_hit;
    logic [2:0]          fsel_idx;
    logic [31:0]         rd_data;
    logic [num_pins-1:0] gpio_out_q;
    func_sel_t           func_sel_q [num_pins];

    assign wr_en = i_sel && (i_req.write_n != access_none);

    // Function selects are word registers from 0x20 upwards
    assign fsel_hit = i_req.offset[5] && (i_req.offset[1:0] == 2'b00);
    assign fsel_idx = i_req.offset[4:2];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            gpio_out_q <= '0;
            for (int p = 0; p < num_pins; p++) begin
                func_sel_q[p] <= (p < func_sel_default_pins) ? sel_timer : sel_gpio;
            end
        end else if (wr_en) begin
            if (i_req.offset == off_out) begin
                gpio_out_q <= i_req.data[num_pins-1:0];
            end
            for (int p = 0; p < num_pins; p++) begin
                if (fsel_hit && fsel_idx == 3'(p)) begin
                    func_sel_q[p] <= func_sel_t'(i_req.data[4:0]);
                end
            end
        end
    end

    always_comb begin
        rd_data = '0;
        if (i_req.offset == off_out) begin
            rd_data = 32'(gpio_out_q);
        end else if (i_req.offset == off_in) begin
            rd_data = 32'(i_ui_in);
        end else if (fsel_hit) begin
            rd_data = 32'(func_sel_q[fsel_idx]);
        end
    end

    assign o_rsp.data  = (i_req.read_n != access_none) ? rd_data : '0;
    assign o_rsp.ready = 1'b1;
    assign o_pins      = gpio_out_q;
    assign o_func_sel  = func_sel_q;

endmodule

/* hw/interval_timer.sv */
/*
 * Interval timer
 * Free-running up-counter that wraps on a compare match, raising an
 * interrupt flag and toggling output pin 0
 */
module interval_timer (
    input  logic                    clk,
    input  logic                    rst_n,
    input  periph_pkg::periph_req_t i_req,
    output periph_pkg::periph_rsp_t o_rsp,
    output logic [7:0]              o_pins,
    output logic                    o_irq
);
    import periph_pkg::*;

    localparam logic [5:0] off_ctrl    = 6'h0;
    localparam logic [5:0] off_compare = 6'h4;
    localparam logic [5:0] off_count   = 6'h8;
    localparam logic [5:0] off_status  = 6'hc;

    logic        wr_en;
    logic        enable_q;
    logic        irq_q;
    logic        toggle_q;
    logic [31:0] compare_q;
    logic [31:0] count_q;
    logic [31:0] rd_data;

    // Narrow writes only replace the low byte lanes
    function automatic logic [31:0] merge_lanes(input logic [31:0] old_val,
                                                input logic [31:0] wdata,
                                                input access_t     size);
        case (size)
            access_byte: merge_lanes = {old_val[31:8], wdata[7:0]};
            access_half: merge_lanes = {old_val[31:16], wdata[15:0]};
            default:     merge_lanes = wdata;
        endcase
    endfunction

    assign wr_en = (i_req.write_n != access_none);

    always_ff @(posedge clk) begin
        if (wr_en && i_req.offset == off_compare) begin
            compare_q <= merge_lanes(compare_q, i_req.data, i_req.write_n);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            enable_q <= 1'b0;
            irq_q    <= 1'b0;
            toggle_q <= 1'b0;
            count_q  <= '0;
        end else begin
            if (wr_en && i_req.offset == off_ctrl) begin
                enable_q <= i_req.data[0];
            end
            if (wr_en && i_req.offset == off_status) begin
                irq_q <= 1'b0;
            end
            // A match in the same cycle as a clear keeps the flag set
            if (enable_q) begin
                if (count_q == compare_q) begin
                    count_q  <= '0;
                    irq_q    <= 1'b1;
                    toggle_q <= ~toggle_q;
                end else begin
                    count_q <= count_q + 32'd1;
                end
            end
        end
    end

    always_comb begin
        case (i_req.offset)
            off_ctrl:    rd_data = {31'h0, enable_q};
            off_compare: rd_data = compare_q;
            off_count:   rd_data = count_q;
            off_status:  rd_data = {31'h0, irq_q};
            default:     rd_data = '0;
        endcase
    end

    assign o_rsp.data  = (i_req.read_n != access_none) ? rd_data : '0;
    assign o_rsp.ready = 1'b1;
    assign o_pins      = {6'h0, irq_q, toggle_q};
    assign o_irq       = irq_q;

endmodule

/* hw/out_pin_mux.sv */
/*
 * Output pin multiplexer
 * Each pin takes its bit from the peripheral named by its function select
 */
module out_pin_mux #(
    parameter int num_pins = 8
) (
    input  periph_pkg::func_sel_t i_func_sel [num_pins],
    input  logic [num_pins-1:0]   i_gpio_pins,
    input  logic [num_pins-1:0]   i_timer_pins,
    input  logic [num_pins-1:0]   i_byte_bank_pins,
    output logic [num_pins-1:0]   o_uo_out
);
    import periph_pkg::*;

    always_comb begin
        for (int p = 0; p < num_pins; p++) begin
            // Unpopulated sources drive zero
            o_uo_out[p] = 1'b0;
            if (i_func_sel[p].simple) begin
                if (i_func_sel[p].slot == 4'(slot_byte_bank)) begin
                    o_uo_out[p] = i_byte_bank_pins[p];
                end
            end else begin
                case (i_func_sel[p].slot)
                    4'(slot_gpio):  o_uo_out[p] = i_gpio_pins[p];
                    4'(slot_timer): o_uo_out[p] = i_timer_pins[p];
                    default:        o_uo_out[p] = 1'b0;
                endcase
            end
        end
    end

endmodule

/* hw/periph_addr_decode.sv */
/*
 * Peripheral address decoder
 * Forms one-hot user and simple slot selects and returns the
 * response of the addressed slot
 */
module periph_addr_decode (
    input  periph_pkg::periph_addr_u                   i_addr,
    input  periph_pkg::periph_rsp_t                    i_gpio_rsp,
    input  periph_pkg::periph_rsp_t                    i_timer_rsp,
    input  logic [7:0]                                 i_byte_bank_data,
    output logic [periph_pkg::num_user_slots-1:0]      o_user_sel,
    output logic [periph_pkg::num_simple_slots-1:0]    o_simple_sel,
    output periph_pkg::periph_rsp_t                    o_rsp
);
    import periph_pkg::*;

    always_comb begin
        o_user_sel   = '0;
        o_simple_sel = '0;
        // Empty slots and unmapped regions read zero and are ready
        o_rsp.data   = '0;
        o_rsp.ready  = 1'b1;

        if (i_addr.simple.region == simple_region) begin
            o_simple_sel[i_addr.simple.slot] = 1'b1;
            if (i_addr.simple.slot == 4'(slot_byte_bank)) begin
                o_rsp.data = {24'h0, i_byte_bank_data};
            end
        end else if (i_addr.user.region == user_region) begin
            o_user_sel[i_addr.user.slot] = 1'b1;
            case (i_addr.user.slot)
                4'(slot_gpio):  o_rsp = i_gpio_rsp;
                4'(slot_timer): o_rsp = i_timer_rsp;
                default:        ;
            endcase
        end
    end

endmodule

/* hw/periph_bus_top.sv */
/*
 * Peripheral bus wrapper
 * Decodes core accesses into user and simple slots, registers read data,
 * and routes the output pins through the GPIO function selects
 */
module periph_bus_top #(
    parameter int num_pins = 8
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [num_pins-1:0]      i_ui_in,
    output logic [num_pins-1:0]      o_uo_out,
    input  periph_pkg::periph_addr_u i_addr,
    input  logic [31:0]              i_data_in,
    input  periph_pkg::access_t      i_data_write_n,
    input  periph_pkg::access_t      i_data_read_n,
    input  logic                     i_data_read_complete,
    output logic [31:0]              o_data_out,
    output logic                     o_data_ready,
    output logic                     o_timer_irq
);
    import periph_pkg::*;

    logic [num_user_slots-1:0]   user_sel;
    logic [num_simple_slots-1:0] simple_sel;
    logic                        read_mask;
    access_t                     read_n_peri;

    periph_req_t gpio_req;
    periph_req_t timer_req;
    periph_rsp_t gpio_rsp;
    periph_rsp_t timer_rsp;
    periph_rsp_t sel_rsp;

    func_sel_t func_sel [num_pins];

    logic [num_pins-1:0] gpio_pins;
    logic [7:0]          timer_pins;
    logic [7:0]          byte_bank_pins;
    logic [7:0]          byte_bank_data;
    logic                byte_bank_write;

    // No second read reaches a peripheral while the result is still held
    assign read_n_peri = read_mask ? access_none : i_data_read_n;

    assign gpio_req.write_n  = user_sel[slot_gpio] ? i_data_write_n : access_none;
    assign gpio_req.read_n   = user_sel[slot_gpio] ? read_n_peri : access_none;
    assign gpio_req.offset   = i_addr.user.offset;
    assign gpio_req.data     = i_data_in;

    assign timer_req.write_n = user_sel[slot_timer] ? i_data_write_n : access_none;
    assign timer_req.read_n  = user_sel[slot_timer] ? read_n_peri : access_none;
    assign timer_req.offset  = i_addr.user.offset;
    assign timer_req.data    = i_data_in;

    assign byte_bank_write = (i_data_write_n != access_none) && simple_sel[slot_byte_bank];

    periph_addr_decode u_decode (
        .i_addr           (i_addr),
        .i_gpio_rsp       (gpio_rsp),
        .i_timer_rsp      (timer_rsp),
        .i_byte_bank_data (byte_bank_data),
        .o_user_sel       (user_sel),
        .o_simple_sel     (simple_sel),
        .o_rsp            (sel_rsp)
    );

    read_data_hold u_read_hold (
        .clk                  (clk),
        .rst_n                (rst_n),
        .i_data_read_n        (i_data_read_n),
        .i_data_write_n       (i_data_write_n),
        .i_rsp                (sel_rsp),
        .i_data_read_complete (i_data_read_complete),
        .o_data_out           (o_data_out),
        .o_data_ready         (o_data_ready),
        .o_read_mask          (read_mask)
    );

    gpio_ctrl #(.num_pins(num_pins)) u_gpio (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_sel      (user_sel[slot_gpio]),
        .i_req      (gpio_req),
        .i_ui_in    (i_ui_in),
        .o_rsp      (gpio_rsp),
        .o_pins     (gpio_pins),
        .o_func_sel (func_sel)
    );

    out_pin_mux #(.num_pins(num_pins)) u_pin_mux (
        .i_func_sel       (func_sel),
        .i_gpio_pins      (gpio_pins),
        .i_timer_pins     (timer_pins),
        .i_byte_bank_pins (byte_bank_pins),
        .o_uo_out         (o_uo_out)
    );

    interval_timer u_timer (
        .clk    (clk),
        .rst_n  (rst_n),
        .i_req  (timer_req),
        .o_rsp  (timer_rsp),
        .o_pins (timer_pins),
        .o_irq  (o_timer_irq)
    );

    byte_reg_bank u_byte_bank (
        .clk      (clk),
        .rst_n    (rst_n),
        .i_write  (byte_bank_write),
        .i_offset (i_addr.simple.offset),
        .i_data   (i_data_in[7:0]),
        .o_data   (byte_bank_data),
        .o_pins   (byte_bank_pins)
    );

endmodule

/* hw/periph_pkg.sv */
/*
 * Peripheral bus definitions
 * Address map, slot numbering, access-size codes and the request,
 * response and pin function-select types shared by the bus wrapper
 */
package periph_pkg;

    localparam int addr_w           = 11;
    localparam int num_user_slots   = 16;
    localparam int num_simple_slots = 16;

    // Populated slots
    localparam int slot_gpio      = 1;
    localparam int slot_timer     = 2;
    localparam int slot_byte_bank = 0;

    // Region codes in the top address bits
    localparam logic       user_region   = 1'b0;
    localparam logic [1:0] simple_region = 2'b10;

    // Pins below this index select the timer after reset
    localparam int func_sel_default_pins = 2;

    // Active low access size, as driven by the core
    typedef enum logic [1:0] {
        access_byte = 2'b00,
        access_half = 2'b01,
        access_word = 2'b10,
        access_none = 2'b11
    } access_t;

    // Word interface view, 64 bytes per slot
    typedef struct packed {
        logic              region;
        logic [3:0]        slot;
        logic [addr_w-6:0] offset;
    } user_addr_t;

    // Byte interface view, 16 bytes per slot
    typedef struct packed {
        logic [1:0] region;
        logic       unused;
        logic [3:0] slot;
        logic [3:0] offset;
    } simple_addr_t;

    typedef union packed {
        user_addr_t   user;
        simple_addr_t simple;
    } periph_addr_u;

    typedef struct packed {
        access_t     write_n;
        access_t     read_n;
        logic [5:0]  offset;
        logic [31:0] data;
    } periph_req_t;

    typedef struct packed {
        logic [31:0] data;
        logic        ready;
    } periph_rsp_t;

    typedef struct packed {
        logic       simple;
        logic [3:0] slot;
    } func_sel_t;

endpackage

/* hw/read_data_hold.sv */
/*
 * Read data register
 * Captures the selected slot's read data and keeps it stable until
 * the core signals read complete
 */
module read_data_hold (
    input  logic                    clk,
    input  logic                    rst_n,
    input  periph_pkg::access_t     i_data_read_n,
    input  periph_pkg::access_t     i_data_write_n,
    input  periph_pkg::periph_rsp_t i_rsp,
    input  logic                    i_data_read_complete,
    output logic [31:0]             o_data_out,
    output logic                    o_data_ready,
    output logic                    o_read_mask
);
    import periph_pkg::*;

    logic        read_req;
    logic        capture;
    logic        hold_q;
    logic        ready_q;
    logic [31:0] data_q;

    assign read_req = (i_data_read_n != access_none);
    assign capture  = read_req && i_rsp.ready && !hold_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hold_q  <= 1'b0;
            ready_q <= 1'b0;
        end else begin
            if (i_data_read_complete) begin
                hold_q <= 1'b0;
            end
            if (capture) begin
                hold_q <= 1'b1;
            end
            ready_q <= read_req && i_rsp.ready;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            data_q <= i_rsp.data;
        end
    end

    assign o_data_out   = data_q;
    // Writes complete in the cycle they are issued
    assign o_data_ready = ready_q || (i_data_write_n != access_none);
    assign o_read_mask  = hold_q;

endmodule

/* run_sim.sh */
#!/bin/sh
# Build the peripheral bus testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module tb_periph_bus -f filelist.f \
    && ./obj_dir/Vtb_periph_bus > sim.log 2>&1 \
    || echo "run_sim: build or run error"

if [ -f sim.log ]; then
    cat sim.log
fi

grep -qx "Simulation finished: PASS" sim.log 2>/dev/null && echo "run_sim: passed" && exit 0 \
    || { echo "run_sim: failed"; exit 1; }

/* verification/tb_periph_tasks.svh */
/*
 * Bus access tasks and directed tests for the peripheral bus wrapper
 * Included into the testbench module body
 */
`ifndef TB_PERIPH_TASKS_SVH
`define TB_PERIPH_TASKS_SVH

// Word slots are 64 bytes apart below 0x400
function automatic logic [10:0] user_addr(input int slot, input int offset);
    return {1'b0, 4'(slot), 6'(offset)};
endfunction

// Byte slots sit in region 10, 16 bytes each
function automatic logic [10:0] simple_addr(input int slot, input int offset);
    return {2'b10, 1'b0, 4'(slot), 4'(offset)};
endfunction

function automatic logic [10:0] fsel_addr(input int pin);
    return user_addr(slot_gpio, 32 + 4 * pin);
endfunction

task automatic bus_write(input logic [10:0] addr, input logic [31:0] data,
                         input access_t size);
    @(posedge clk);
    bus_addr     <= addr;
    data_in      <= data;
    data_write_n <= size;
    @(negedge clk);
    expect_true(data_ready, "data ready was low during a write");
    @(posedge clk);
    data_write_n <= access_none;
endtask

// Issues a word read and returns the data without releasing it
task automatic read_issue(input logic [10:0] addr, output logic [31:0] data);
    int waited;
    @(posedge clk);
    bus_addr    <= addr;
    data_read_n <= access_word;
    @(negedge clk);
    expect_true(!data_ready, "data ready was high in the request cycle");
    @(posedge clk);
    data_read_n <= access_none;
    waited = 1;
    @(negedge clk);
    while (!data_ready && waited < read_wait_limit) begin
        @(negedge clk);
        waited++;
    end
    expect_true(data_ready, "data ready never rose after a read");
    check_value("read latency", 32'(waited), 32'd1);
    data = data_out;
endtask

task automatic read_release();
    @(posedge clk);
    read_complete <= 1'b1;
    @(posedge clk);
    read_complete <= 1'b0;
endtask

task automatic bus_read(input logic [10:0] addr, output logic [31:0] data);
    read_issue(addr, data);
    read_release();
endtask

task automatic reset_defaults();
    logic [31:0] rd;
    logic [31:0] exp;
    open_test();
    @(negedge clk);
    check_value("o_uo_out", {24'h0, uo_out}, 32'h0);
    expect_true(!timer_irq, "timer interrupt was set after reset");
    for (int p = 0; p < 8; p++) begin
        exp = (p < 2) ? {27'h0, route_timer} : {27'h0, route_gpio};
        bus_read(fsel_addr(p), rd);
        check_value("func_sel readback", rd, exp);
    end
    report_test("reset");
endtask

task automatic gpio_access();
    logic [31:0] rnd;
    logic [31:0] rd;
    open_test();
    for (int p = 0; p < 8; p++) begin
        bus_write(fsel_addr(p), {27'h0, route_gpio}, access_word);
    end
    rnd = $random(seed);
    gpio_shadow = rnd[7:0];
    bus_write(user_addr(slot_gpio, 0), rnd, access_word);
    @(negedge clk);
    check_value("o_uo_out", {24'h0, uo_out}, {24'h0, gpio_shadow});
    bus_read(user_addr(slot_gpio, 0), rd);
    check_value("gpio output readback", rd, {24'h0, gpio_shadow});
    rnd = $random(seed);
    @(posedge clk);
    ui_in <= rnd[7:0];
    bus_read(user_addr(slot_gpio, 4), rd);
    check_value("gpio input readback", rd, {24'h0, rnd[7:0]});
    report_test("gpio");
endtask

task automatic bank_routing();
    logic [31:0] rnd;
    logic [31:0] rd;
    logic [7:0]  bank_val;
    open_test();
    rnd = $random(seed);
    bank_val = rnd[7:0];
    bus_write(simple_addr(slot_byte_bank, 0), rnd, access_byte);
    for (int p = 4; p < 8; p++) begin
        bus_write(fsel_addr(p), {27'h0, route_bank}, access_word);
    end
    @(negedge clk);
    check_value("o_uo_out", {24'h0, uo_out}, {24'h0, bank_val[7:4], gpio_shadow[3:0]});
    // Only the low data byte lands in the bank
    rnd = $random(seed);
    bus_write(simple_addr(slot_byte_bank, 5), rnd, access_byte);
    bus_read(simple_addr(slot_byte_bank, 5), rd);
    check_value("bank register 5", rd, {24'h0, rnd[7:0]});
    report_test("byte bank routing");
endtask

task automatic read_handshake();
    logic [31:0] rnd;
    logic [31:0] rd;
    logic [31:0] held;
    open_test();
    rnd = $random(seed);
    read_issue(user_addr(slot_gpio, 0), held);
    check_value("o_data_out", held, {24'h0, gpio_shadow});
    // Change the source register while the old value is still held
    bus_write(user_addr(slot_gpio, 0), {24'h0, rnd[7:0]}, access_word);
    // A second read of the changed register must not replace the held data
    @(posedge clk);
    data_read_n <= access_word;
    @(posedge clk);
    data_read_n <= access_none;
    repeat (4) begin
        @(negedge clk);
        check_value("o_data_out while held", data_out, {24'h0, gpio_shadow});
    end
    read_release();
    gpio_shadow = rnd[7:0];
    bus_read(user_addr(slot_gpio, 0), rd);
    check_value("gpio output after release", rd, {24'h0, gpio_shadow});
    bus_read(user_addr(5, 0), rd);
    check_value("empty user slot", rd, 32'h0);
    report_test("read handshake");
endtask

task automatic timer_irq_flow();
    logic [31:0] rnd;
    logic [31:0] low;
    logic [31:0] rd;
    int          cmp;
    int          waited;
    open_test();
    rnd = $random(seed);
    cmp = 5 + int'(rnd[3:0]);
    bus_write(fsel_addr(0), {27'h0, route_timer}, access_word);
    bus_write(fsel_addr(1), {27'h0, route_timer}, access_word);
    bus_write(user_addr(slot_timer, 4), 32'(cmp), access_word);
    bus_write(user_addr(slot_timer, 0), 32'h1, access_word);
    waited = 0;
    @(negedge clk);
    while (!timer_irq && waited < cmp + 10) begin
        @(negedge clk);
        waited++;
    end
    expect_true(timer_irq, "timer interrupt did not rise within compare plus 10 cycles");
    check_value("o_uo_out[1]", {31'h0, uo_out[1]}, 32'h1);
    check_value("o_uo_out[0]", {31'h0, uo_out[0]}, 32'h1);
    // Stop the counter so no new match races the status clear
    bus_write(user_addr(slot_timer, 0), 32'h0, access_word);
    bus_read(user_addr(slot_timer, 8), rd);
    expect_true(rd < 32'(cmp), "timer count was not below the compare value");
    bus_write(user_addr(slot_timer, 12), 32'h0, access_word);
    @(negedge clk);
    expect_true(!timer_irq, "timer interrupt stayed set after the status write");
    rnd = $random(seed);
    bus_write(user_addr(slot_timer, 4), rnd, access_word);
    low = $random(seed);
    bus_write(user_addr(slot_timer, 4), low, access_byte);
    bus_read(user_addr(slot_timer, 4), rd);
    check_value("compare after byte write", rd, {rnd[31:8], low[7:0]});
    rnd = {rnd[31:8], low[7:0]};
    low = $random(seed);
    bus_write(user_addr(slot_timer, 4), low, access_half);
    bus_read(user_addr(slot_timer, 4), rd);
    check_value("compare after half write", rd, {rnd[31:16], low[15:0]});
    report_test("timer");
endtask

`endif

/* verification/tb_periph_bus.sv */
/*
 * Peripheral bus wrapper testbench
 * Clock, reset, DUT, timeout watchdog and the sequence of directed tests
 */
module tb_periph_bus;
    import periph_pkg::*;

    // The five tests take a few hundred cycles, so this leaves a wide margin
    localparam int timeout_cycles  = 3000;
    localparam int read_wait_limit = 8;

    // Function-select codes {simple, slot}
    localparam logic [4:0] route_gpio  = 5'h01;
    localparam logic [4:0] route_timer = 5'h02;
    localparam logic [4:0] route_bank  = 5'h10;

    logic         clk;
    logic         rst_n;
    logic [7:0]   ui_in;
    logic [7:0]   uo_out;
    periph_addr_u bus_addr;
    logic [31:0]  data_in;
    access_t      data_write_n;
    access_t      data_read_n;
    logic         read_complete;
    logic [31:0]  data_out;
    logic         data_ready;
    logic         timer_irq;

    integer     seed = 32'hd6ad;
    int         cycle_count = 0;
    int         test_errs;
    int         err_total;
    int         tests_run;
    int         tests_failed;
    logic [7:0] gpio_shadow;

    periph_bus_top #(.num_pins(8)) u_dut (
        .clk                  (clk),
        .rst_n                (rst_n),
        .i_ui_in              (ui_in),
        .o_uo_out             (uo_out),
        .i_addr               (bus_addr),
        .i_data_in            (data_in),
        .i_data_write_n       (data_write_n),
        .i_data_read_n        (data_read_n),
        .i_data_read_complete (read_complete),
        .o_data_out           (data_out),
        .o_data_ready         (data_ready),
        .o_timer_irq          (timer_irq)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    initial begin
        wait (cycle_count >= timeout_cycles);
        $display("Timeout: the tests did not end within %0d cycles", timeout_cycles);
        $display("Simulation finished: FAIL");
        $finish;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("FAIL t=%0t %s got 0x%08h expected 0x%08h", $time, name, got, exp);
            test_errs++;
        end
    endtask

    task automatic expect_true(input logic cond, input string what);
        assert (cond === 1'b1) else begin
            $display("Error at t=%0t: %s", $time, what);
            test_errs++;
        end
    endtask

    task automatic open_test();
        test_errs = 0;
    endtask

    task automatic report_test(input string name);
        tests_run++;
        err_total += test_errs;
        if (test_errs == 0) begin
            $display("%s test: ok", name);
        end else begin
            tests_failed++;
            $display("%s test: %0d errors", name, test_errs);
        end
    endtask

    `include "tb_periph_tasks.svh"

    initial begin
        err_total    = 0;
        tests_run    = 0;
        tests_failed = 0;
        gpio_shadow  = 8'h00;
        rst_n         <= 1'b0;
        ui_in         <= 8'h00;
        bus_addr      <= '0;
        data_in       <= 32'h0;
        data_write_n  <= access_none;
        data_read_n   <= access_none;
        read_complete <= 1'b0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;

        reset_defaults();
        gpio_access();
        bank_routing();
        read_handshake();
        timer_irq_flow();

        $display("Tests run: %0d, tests failed: %0d, errors: %0d",
                 tests_run, tests_failed, err_total);
        if (err_total == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule
